/* common/cpu_cfg.svh */
// -------------------------------------
// cpu configuration macros
// -------------------------------------
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath
`define CPU_DATA_W      16
`define CPU_REG_CNT     16
// word address of code and data
`define CPU_PC_W        11

// instruction cache geometry
`define CPU_LINE_W      7
`define CPU_TAG_W       4
// burst length field for one line refill
`define CPU_LINE_LEN    127

// dram address map, code and data share one region
`define CPU_AXI_ADDR_W  32
`define CPU_DRAM_BASE   32'h0000_1000

`endif

/* common/cpu_pkg.sv */
// -------------------------------------
// cpu shared types
// -------------------------------------
`include "cpu_cfg.svh"

package cpu_pkg;

	typedef enum logic [2:0] {
		R_ADDSUB = 3'b000,
		R_SLTMUL = 3'b001,
		LOAD     = 3'b010,
		STORE    = 3'b011,
		BEQ      = 3'b100,
		JUMP     = 3'b101
	} opcode_e;

	typedef logic signed [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_PC_W-1:0] pc_t;

	// -------------------------------------
	// instruction formats
	// -------------------------------------
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [3:0] rd;
		logic       func;
	} r_fmt_t;

	typedef struct packed {
		opcode_e           opcode;
		logic [3:0]        rs;
		logic [3:0]        rt;
		logic signed [4:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		pc_t        target;
		logic [1:0] pad;
	} j_fmt_t;

	// one fetched word read three ways by opcode
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	// -------------------------------------
	// axi channel payloads
	// -------------------------------------
	typedef struct packed {
		logic [`CPU_AXI_ADDR_W-1:0] addr;
		logic [6:0]                 len;
	} axi_ar_t;

	typedef struct packed {
		word_t      data;
		logic [1:0] resp;
		logic       last;
	} axi_r_t;

	typedef struct packed {
		logic [`CPU_AXI_ADDR_W-1:0] addr;
	} axi_aw_t;

	typedef struct packed {
		word_t data;
		logic  last;
	} axi_w_t;

	// core request to the data port
	typedef struct packed {
		logic  write;
		pc_t   addr;
		word_t wdata;
	} mem_req_t;

endpackage

/* core/reg_file.sv */
// -------------------------------------
// register file
// -------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file (
	input  logic           clk,
	input  logic           rst_n,
	input  logic [3:0]     rs_addr,
	input  logic [3:0]     rt_addr,
	output cpu_pkg::word_t rs_data,
	output cpu_pkg::word_t rt_data,
	input  logic           we,
	input  logic [3:0]     wr_addr,
	input  cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	word_t regs [`CPU_REG_CNT];

	// both read ports are registered
	always_ff @(posedge clk) begin
		rs_data <= regs[rs_addr];
		rt_data <= regs[rt_addr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

/* core/cpu_core.sv */
// -------------------------------------
// multi-cycle cpu core
// -------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_core (
	input  logic              clk,
	input  logic              rst_n,
	output logic              fetch_req,
	output cpu_pkg::pc_t      pc,
	input  logic              fetch_done,
	input  cpu_pkg::instr_t   instr,
	output logic              mem_valid,
	output cpu_pkg::mem_req_t mem_req,
	input  logic              mem_done,
	input  cpu_pkg::word_t    rdata,
	output logic              io_stall
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXECUTE, MEM, WRITE_BACK} state_e;

	state_e     state;
	state_e     next_state;
	instr_t     ir;
	opcode_e    opcode;
	word_t      rs_data;
	word_t      rt_data;
	word_t      alu_out;
	word_t      result;
	word_t      eff_addr;
	pc_t        pc_inc;
	pc_t        br_off;
	logic       rf_we;
	logic [3:0] wr_addr;

	assign opcode = ir.r_fmt.opcode;

	// operands are registered while the FSM sits in DECODE
	reg_file u_rf (
		.clk(clk), .rst_n(rst_n),
		.rs_addr(ir.r_fmt.rs), .rt_addr(ir.r_fmt.rt),
		.rs_data(rs_data), .rt_data(rt_data),
		.we(rf_we), .wr_addr(wr_addr), .wr_data(result)
	);

	// -------------------------------------
	// state machine
	// -------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			IDLE: next_state = FETCH;
			FETCH: if (fetch_done) next_state = DECODE;
			DECODE: next_state = EXECUTE;
			EXECUTE: begin
				case (opcode)
					R_ADDSUB, R_SLTMUL: next_state = WRITE_BACK;
					LOAD, STORE: next_state = MEM;
					// beq, jump and unused opcodes retire here
					default: next_state = FETCH;
				endcase
			end
			MEM: if (mem_done) next_state = mem_req.write ? FETCH : WRITE_BACK;
			WRITE_BACK: next_state = FETCH;
			default: next_state = IDLE;
		endcase
	end

	assign fetch_req = (state == FETCH);
	assign mem_valid = (state == MEM);

	// -------------------------------------
	// alu and address math
	// -------------------------------------
	always_comb begin
		case ({opcode == R_SLTMUL, ir.r_fmt.func})
			2'b00: alu_out = rs_data + rt_data;
			2'b01: alu_out = rs_data - rt_data;
			// signed compare, result is 0 or 1
			2'b10: alu_out = {{(`CPU_DATA_W-1){1'b0}}, rs_data < rt_data};
			default: alu_out = rs_data * rt_data;
		endcase
	end

	// rs plus sign-extended imm
	assign eff_addr = rs_data + {{(`CPU_DATA_W-5){ir.i_fmt.imm[4]}}, ir.i_fmt.imm};
	assign pc_inc = pc + `CPU_PC_W'(1);
	assign br_off = {{(`CPU_PC_W-5){ir.i_fmt.imm[4]}}, ir.i_fmt.imm};

	// load writes rt, r-type writes rd
	assign rf_we = (state == WRITE_BACK);
	assign wr_addr = (opcode == LOAD) ? ir.i_fmt.rt : ir.r_fmt.rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			pc <= '0;
			io_stall <= 1'b1;
		end else begin
			state <= next_state;
			// one low cycle on each return to FETCH, none on the first one
			io_stall <= !(next_state == FETCH && state != FETCH && state != IDLE);
			if (state == EXECUTE) begin
				case (opcode)
					JUMP: pc <= ir.j_fmt.target;
					BEQ: pc <= (rs_data == rt_data) ? pc_inc + br_off : pc_inc;
					default: pc <= pc_inc;
				endcase
			end
		end
	end

	// instruction, result and memory request
	always_ff @(posedge clk) begin
		if (state == FETCH && fetch_done) begin
			ir <= instr;
		end
		if (state == EXECUTE) begin
			result <= alu_out;
			mem_req.write <= (opcode == STORE);
			mem_req.addr <= eff_addr[`CPU_PC_W-1:0];
			mem_req.wdata <= rt_data;
		end
		if (state == MEM && mem_done && !mem_req.write) begin
			result <= rdata;
		end
	end

endmodule

/* icache/inst_cache.sv */
// -------------------------------------
// direct-mapped instruction cache
// -------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module inst_cache (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             fetch_req,
	input  cpu_pkg::pc_t     pc,
	output logic             fetch_done,
	output cpu_pkg::instr_t  instr,
	output logic             ar_valid,
	output cpu_pkg::axi_ar_t ar_req,
	input  logic             ar_ready,
	input  cpu_pkg::axi_r_t  r,
	input  logic             r_valid,
	output logic             r_ready
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {C_IDLE, C_REQ, C_FILL, C_READ, C_INSTR, C_DONE} cstate_e;

	cstate_e               state;
	logic [`CPU_TAG_W-1:0] tag;
	logic                  line_valid;
	logic [`CPU_LINE_W-1:0] fill_cnt;
	word_t                 line_mem [2**`CPU_LINE_W];
	word_t                 rd_word;
	logic                  hit;
	pc_t                   line_base;

	assign hit = line_valid && (tag == pc[`CPU_PC_W-1 -: `CPU_TAG_W]);

	// refill starts at the line base, tag then zero index
	assign line_base = {pc[`CPU_PC_W-1 -: `CPU_TAG_W], {`CPU_LINE_W{1'b0}}};
	assign ar_req.addr = `CPU_DRAM_BASE
		+ {{(`CPU_AXI_ADDR_W-`CPU_PC_W-1){1'b0}}, line_base, 1'b0};
	assign ar_req.len = 7'(`CPU_LINE_LEN);

	assign ar_valid = (state == C_REQ);
	assign r_ready = (state == C_FILL);
	assign fetch_done = (state == C_DONE);

	// -------------------------------------
	// control
	// -------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= C_IDLE;
			tag <= '0;
			line_valid <= 1'b0;
			fill_cnt <= '0;
		end else begin
			case (state)
				// tag compare cycle
				C_IDLE: if (fetch_req) state <= hit ? C_READ : C_REQ;
				C_REQ: begin
					if (ar_ready) begin
						fill_cnt <= '0;
						state <= C_FILL;
					end
				end
				C_FILL: begin
					if (r_valid) begin
						fill_cnt <= fill_cnt + `CPU_LINE_W'(1);
						// line complete, compare again and take the hit path
						if (r.last) begin
							tag <= pc[`CPU_PC_W-1 -: `CPU_TAG_W];
							line_valid <= 1'b1;
							state <= C_IDLE;
						end
					end
				end
				C_READ: state <= C_INSTR;
				C_INSTR: state <= C_DONE;
				default: state <= C_IDLE;
			endcase
		end
	end

	// line storage, array read and instruction register
	always_ff @(posedge clk) begin
		if (state == C_FILL && r_valid) begin
			line_mem[fill_cnt] <= r.data;
		end
		if (state == C_READ) begin
			rd_word <= line_mem[pc[`CPU_LINE_W-1:0]];
		end
		if (state == C_INSTR) begin
			instr <= instr_t'(rd_word);
		end
	end

endmodule

/* hdl/data_port.sv */
// -------------------------------------
// single-beat data port
// -------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module data_port (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_valid,
	input  cpu_pkg::mem_req_t mem_req,
	output logic              mem_done,
	output cpu_pkg::word_t    rdata,
	output logic              ar_valid,
	output cpu_pkg::axi_ar_t  ar_req,
	input  logic              ar_ready,
	input  cpu_pkg::axi_r_t   r,
	input  logic              r_valid,
	output logic              r_ready,
	output cpu_pkg::axi_aw_t  aw,
	output logic              awvalid,
	input  logic              awready,
	output cpu_pkg::axi_w_t   w,
	output logic              wvalid,
	input  logic              wready,
	input  logic              bvalid,
	output logic              bready
);
	typedef enum logic [2:0] {D_IDLE, D_AR, D_R, D_DONE, D_AW, D_W, D_B} dstate_e;

	dstate_e                    state;
	logic [`CPU_AXI_ADDR_W-1:0] byte_addr;

	// base plus twice the word address
	assign byte_addr = `CPU_DRAM_BASE
		+ {{(`CPU_AXI_ADDR_W-`CPU_PC_W-1){1'b0}}, mem_req.addr, 1'b0};

	// load side, one beat
	assign ar_req.addr = byte_addr;
	assign ar_req.len = 7'd0;
	assign ar_valid = (state == D_AR);
	assign r_ready = (state == D_R);

	// store side, W follows the AW transfer
	assign aw.addr = byte_addr;
	assign w.data = mem_req.wdata;
	assign w.last = 1'b1;
	assign awvalid = (state == D_AW);
	assign wvalid = (state == D_W);
	assign bready = (state == D_B);

	assign mem_done = (state == D_DONE) || (state == D_B && bvalid);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= D_IDLE;
		end else begin
			case (state)
				D_IDLE: if (mem_valid) state <= mem_req.write ? D_AW : D_AR;
				D_AR: if (ar_ready) state <= D_R;
				D_R: if (r_valid) state <= D_DONE;
				D_AW: if (awready) state <= D_W;
				D_W: if (wready) state <= D_B;
				D_B: if (bvalid) state <= D_IDLE;
				default: state <= D_IDLE;
			endcase
		end
	end

	// load data is handed back one cycle after the beat
	always_ff @(posedge clk) begin
		if (state == D_R && r_valid) begin
			rdata <= r.data;
		end
	end

endmodule

/* hdl/axi_read_arbiter.sv */
// -------------------------------------
// shared read channel arbiter
// -------------------------------------
`timescale 1ns/1ns

module axi_read_arbiter (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             inst_ar_valid,
	input  cpu_pkg::axi_ar_t inst_ar_req,
	output logic             inst_ar_ready,
	output cpu_pkg::axi_r_t  inst_r,
	output logic             inst_r_valid,
	input  logic             inst_r_ready,
	input  logic             data_ar_valid,
	input  cpu_pkg::axi_ar_t data_ar_req,
	output logic             data_ar_ready,
	output cpu_pkg::axi_r_t  data_r,
	output logic             data_r_valid,
	input  logic             data_r_ready,
	output cpu_pkg::axi_ar_t ar,
	output logic             arvalid,
	input  logic             arready,
	input  cpu_pkg::axi_r_t  r,
	input  logic             rvalid,
	output logic             rready
);
	// owner and pick use 1 for the data port
	logic busy;
	logic owner;
	logic pend;
	logic pend_sel;
	logic sel;

	// a stalled AR keeps its requester, otherwise the data port wins
	assign sel = pend ? pend_sel : data_ar_valid;

	// -------------------------------------
	// address channel
	// -------------------------------------
	assign arvalid = !busy && (inst_ar_valid || data_ar_valid);
	assign ar = sel ? data_ar_req : inst_ar_req;
	assign inst_ar_ready = !busy && !sel && arready;
	assign data_ar_ready = !busy && sel && arready;

	// -------------------------------------
	// data channel, valid only to the owner
	// -------------------------------------
	assign inst_r = r;
	assign data_r = r;
	assign inst_r_valid = busy && !owner && rvalid;
	assign data_r_valid = busy && owner && rvalid;
	assign rready = busy && (owner ? data_r_ready : inst_r_ready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= 1'b0;
			pend <= 1'b0;
			pend_sel <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				busy <= 1'b1;
				owner <= sel;
				pend <= 1'b0;
			end else if (arvalid) begin
				pend <= 1'b1;
				pend_sel <= sel;
			end
			// grant ends with the last beat
			if (busy && rvalid && rready && r.last) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

/* hdl/cpu_top.sv */
// -------------------------------------
// cpu top level
// -------------------------------------
`timescale 1ns/1ns

module cpu_top (
	input  logic             clk,
	input  logic             rst_n,
	output cpu_pkg::axi_ar_t ar,
	output logic             arvalid,
	input  logic             arready,
	input  cpu_pkg::axi_r_t  r,
	input  logic             rvalid,
	output logic             rready,
	output cpu_pkg::axi_aw_t aw,
	output logic             awvalid,
	input  logic             awready,
	output cpu_pkg::axi_w_t  w,
	output logic             wvalid,
	input  logic             wready,
	input  logic [1:0]       bresp,
	input  logic             bvalid,
	output logic             bready,
	output logic             io_stall
);
	import cpu_pkg::*;

	// core to cache
	logic     fetch_req;
	logic     fetch_done;
	pc_t      pc;
	instr_t   instr;
	// core to data port
	logic     mem_valid;
	logic     mem_done;
	mem_req_t mem_req;
	word_t    rdata;
	// requesters to read arbiter
	logic     ic_ar_valid;
	logic     ic_ar_ready;
	axi_ar_t  ic_ar_req;
	axi_r_t   ic_r;
	logic     ic_r_valid;
	logic     ic_r_ready;
	logic     dp_ar_valid;
	logic     dp_ar_ready;
	axi_ar_t  dp_ar_req;
	axi_r_t   dp_r;
	logic     dp_r_valid;
	logic     dp_r_ready;

	cpu_core u_core (
		.clk(clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .pc(pc), .fetch_done(fetch_done), .instr(instr),
		.mem_valid(mem_valid), .mem_req(mem_req), .mem_done(mem_done), .rdata(rdata),
		.io_stall(io_stall)
	);

	inst_cache u_icache (
		.clk(clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .pc(pc), .fetch_done(fetch_done), .instr(instr),
		.ar_valid(ic_ar_valid), .ar_req(ic_ar_req), .ar_ready(ic_ar_ready),
		.r(ic_r), .r_valid(ic_r_valid), .r_ready(ic_r_ready)
	);

	// bresp is ignored, every B transfer completes the store
	data_port u_data_port (
		.clk(clk), .rst_n(rst_n),
		.mem_valid(mem_valid), .mem_req(mem_req), .mem_done(mem_done), .rdata(rdata),
		.ar_valid(dp_ar_valid), .ar_req(dp_ar_req), .ar_ready(dp_ar_ready),
		.r(dp_r), .r_valid(dp_r_valid), .r_ready(dp_r_ready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

	axi_read_arbiter u_rd_arb (
		.clk(clk), .rst_n(rst_n),
		.inst_ar_valid(ic_ar_valid), .inst_ar_req(ic_ar_req), .inst_ar_ready(ic_ar_ready),
		.inst_r(ic_r), .inst_r_valid(ic_r_valid), .inst_r_ready(ic_r_ready),
		.data_ar_valid(dp_ar_valid), .data_ar_req(dp_ar_req), .data_ar_ready(dp_ar_ready),
		.data_r(dp_r), .data_r_valid(dp_r_valid), .data_r_ready(dp_r_ready),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

endmodule

/* verification/axi_dram_model.sv */
// ----------------------------------------
// behavioral axi4 dram
// ----------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module axi_dram_model (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::axi_ar_t ar,
	input  logic             arvalid,
	output logic             arready = 1'b0,
	output cpu_pkg::axi_r_t  r = '0,
	output logic             rvalid = 1'b0,
	input  logic             rready,
	input  cpu_pkg::axi_aw_t aw,
	input  logic             awvalid,
	output logic             awready = 1'b0,
	input  cpu_pkg::axi_w_t  w,
	input  logic             wvalid,
	output logic             wready = 1'b0,
	output logic [1:0]       bresp = 2'b00,
	output logic             bvalid = 1'b0,
	input  logic             bready
);
	import cpu_pkg::*;

	localparam string TRACE_FILE = "verification/cpu_trace.txt";

	logic [15:0] mem [2**`CPU_PC_W];
	logic        loaded = 1'b0;
	logic        rd_busy;
	pc_t         rd_addr;
	logic [6:0]  rd_left;
	logic [1:0]  wr_st;
	pc_t         wr_addr;

	// fill every word from its address, then overlay the M lines
	task automatic load_image();
		int fd;
		int n;
		int a;
		int b;
		string line;
		for (int i = 0; i < 2**`CPU_PC_W; i++) begin
			mem[i] <= 16'(i) ^ 16'hC3A5;
		end
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("dram model cannot open %s", TRACE_FILE);
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 2 && line.getc(0) == "M") begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
				mem[pc_t'(a)] <= 16'(b);
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// read channel with one beat at a time and random gaps
	// ----------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if (!loaded) begin
				load_image();
				loaded <= 1'b1;
			end
			arready <= 1'b0;
			rvalid <= 1'b0;
			rd_busy <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			wr_st <= 2'd0;
		end else begin
			if (!rd_busy) begin
				if (arvalid && arready) begin
					arready <= 1'b0;
					rd_busy <= 1'b1;
					rd_addr <= pc_t'((ar.addr - `CPU_DRAM_BASE) >> 1);
					rd_left <= ar.len;
				end else begin
					arready <= arvalid && ($urandom % 4 != 0);
				end
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
				rd_addr <= rd_addr + pc_t'(1);
				rd_left <= rd_left - 7'd1;
				if (r.last) rd_busy <= 1'b0;
			end else if (!rvalid && ($urandom % 4 != 0)) begin
				// payload stays put until rready
				rvalid <= 1'b1;
				r <= '{data: word_t'(mem[rd_addr]), resp: 2'b00, last: rd_left == 7'd0};
			end

			// write channel steps through AW then W then B
			case (wr_st)
				2'd0: begin
					if (awvalid && awready) begin
						awready <= 1'b0;
						wr_addr <= pc_t'((aw.addr - `CPU_DRAM_BASE) >> 1);
						wr_st <= 2'd1;
					end else begin
						awready <= awvalid && ($urandom % 4 != 0);
					end
				end
				2'd1: begin
					if (wvalid && wready) begin
						wready <= 1'b0;
						mem[wr_addr] <= w.data;
						wr_st <= 2'd2;
					end else begin
						wready <= wvalid && ($urandom % 4 != 0);
					end
				end
				default: begin
					if (bvalid && bready) begin
						bvalid <= 1'b0;
						wr_st <= 2'd0;
					end else if (!bvalid && ($urandom % 4 != 0)) begin
						bvalid <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* verification/tb_cpu.sv */
// ----------------------------------------
// cpu testbench
// ----------------------------------------
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam string TRACE_FILE = "verification/cpu_trace.txt";

	logic       clk;
	logic       rst_n;
	axi_ar_t    ar;
	logic       arvalid;
	logic       arready;
	axi_r_t     r;
	logic       rvalid;
	logic       rready;
	axi_aw_t    aw;
	logic       awvalid;
	logic       awready;
	axi_w_t     w;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	logic       io_stall;

	// expected traffic from the trace
	axi_ar_t exp_ar[$];
	axi_aw_t exp_aw[$];
	axi_w_t  exp_w[$];
	int      exp_retires = 0;
	int      refills = 0;
	int      n_stores = 0;
	bit      trace_done = 0;
	// observed traffic and per-test error counts
	int      retires = 0;
	int      stores_seen = 0;
	int      reads_seen = 0;
	int      rst_errs = 0;
	int      ar_errs = 0;
	int      st_errs = 0;
	int      cnt_errs = 0;
	logic    stall_q = 1'b1;
	axi_aw_t aw_cap;

	cpu_top UUT (
		.clk(clk), .rst_n(rst_n),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.io_stall(io_stall)
	);

	axi_dram_model u_dram (
		.clk(clk), .rst_n(rst_n),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.aw(aw), .awvalid(awvalid), .awready(awready),
		.w(w), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// trace reader, E A and N lines
	// ----------------------------------------
	task automatic read_trace();
		int fd;
		int n;
		int a;
		int b;
		string line;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", TRACE_FILE);
			st_errs++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 2 && line.getc(0) != "#") begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
				case (line.getc(0))
					"E": begin
						exp_aw.push_back('{addr: 32'(a)});
						exp_w.push_back('{data: word_t'(b), last: 1'b1});
					end
					"A": begin
						exp_ar.push_back('{addr: 32'(a), len: 7'(b)});
						if (b != 0) refills++;
					end
					"N": exp_retires = a;
					default: ;
				endcase
			end
		end
		$fclose(fd);
		n_stores = exp_aw.size();
	endtask

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			rst_errs++;
		end
	endtask

	task automatic check_ar(input axi_ar_t act);
		axi_ar_t exp;
		reads_seen++;
		if (exp_ar.size() == 0) begin
			$display("unexpected read request at %0t to address %h", $time, act.addr);
			ar_errs++;
		end else begin
			exp = exp_ar.pop_front();
			if (act !== exp) begin
				$display("mismatch at %0t: ar expected %h/%0d got %h/%0d",
					$time, exp.addr, exp.len, act.addr, act.len);
				ar_errs++;
			end
		end
	endtask

	task automatic check_store(input axi_aw_t aw_act, input axi_w_t w_act);
		axi_aw_t aw_exp;
		axi_w_t  w_exp;
		stores_seen++;
		if (exp_aw.size() == 0) begin
			$display("unexpected store at %0t to address %h", $time, aw_act.addr);
			st_errs++;
		end else begin
			aw_exp = exp_aw.pop_front();
			w_exp = exp_w.pop_front();
			if (aw_act !== aw_exp) begin
				$display("mismatch at %0t: aw.addr expected %h got %h",
					$time, aw_exp.addr, aw_act.addr);
				st_errs++;
			end
			if (w_act !== w_exp) begin
				$display("mismatch at %0t: w expected %h/%b got %h/%b",
					$time, w_exp.data, w_exp.last, w_act.data, w_act.last);
				st_errs++;
			end
		end
	endtask

	task automatic check_count(input int exp, input int act);
		if (act != exp) begin
			$display("mismatch at %0t: retire count expected %0d got %0d", $time, exp, act);
			cnt_errs++;
		end
	endtask

	function automatic void report_test(input string name, input int errs);
		$display("test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
	endfunction

	// bus and retire monitor
	always @(posedge clk) begin
		if (rst_n) begin
			if (arvalid && arready) check_ar(ar);
			if (awvalid && awready) aw_cap = aw;
			if (wvalid && wready) check_store(aw_cap, w);
			if (!io_stall) begin
				retires++;
				// a retire pulse lasts one cycle only
				if (!stall_q) begin
					$display("io_stall stayed low for more than one cycle at %0t", $time);
					cnt_errs++;
				end
			end
			stall_q <= io_stall;
		end
	end

	// watchdog sized from the trace
	initial begin
		wait (trace_done);
		repeat (exp_retires * 400 + refills * 2000) @(posedge clk);
		$display("watchdog expired, the program did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int total;
		void'($urandom(28));
		rst_n = 1'b0;
		read_trace();
		trace_done = 1;
		repeat (3) @(posedge clk);
		check_level("arvalid", 1'b0, arvalid);
		check_level("rready", 1'b0, rready);
		check_level("awvalid", 1'b0, awvalid);
		check_level("wvalid", 1'b0, wvalid);
		check_level("bready", 1'b0, bready);
		check_level("io_stall", 1'b1, io_stall);
		rst_n <= 1'b1;
		report_test("reset", rst_errs);

		while (stores_seen < n_stores) @(posedge clk);
		report_test("stores", st_errs);

		// the last store retires after its B transfer
		@(posedge clk);
		while (io_stall) @(posedge clk);
		@(posedge clk);
		check_count(exp_retires, retires);
		report_test("retire count", cnt_errs);

		if (exp_ar.size() != 0) begin
			$display("%0d expected read requests never appeared", exp_ar.size());
			ar_errs++;
		end
		report_test("read requests", ar_errs);

		total = rst_errs + ar_errs + st_errs + cnt_errs;
		$display("done: %0d stores, %0d reads, %0d retires, %0d errors",
			stores_seen, reads_seen, retires, total);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* verification/cpu_trace.txt */
# M word_addr value : dram image, E byte_addr data : store in order
# A byte_addr len : read request in order, N count : retires, all hex
M 000 4030
M 001 4051
M 002 0246
M 003 0249
M 004 242A
M 005 224C
M 006 224F
M 007 6078
M 008 6099
M 009 60BA
M 00A 60DB
M 00B 60FC
M 00C 4112
M 00D 611D
M 00E 607E
M 00F 413E
M 010 613F
M 011 8241
M 012 6093
M 013 8001
M 014 60F4
M 015 A200
M 016 60F5
M 080 60B6
M 081 801F
M 7F0 0007
M 7F1 0003
M 7F2 1234
A 1000 7F
A 1FE0 00
A 1FE2 00
A 1FE4 00
A 1FFC 00
A 1100 7F
E 1FF0 000A
E 1FF2 0004
E 1FF4 0001
E 1FF6 0000
E 1FF8 0015
E 1FFA 1234
E 1FFC 000A
E 1FFE 000A
E 1FE6 0004
E 1FEC 0001
N 16

/* filelist.f */
+incdir+common
common/cpu_pkg.sv
core/reg_file.sv
core/cpu_core.sv
icache/inst_cache.sv
hdl/data_port.sv
hdl/axi_read_arbiter.sv
hdl/cpu_top.sv
verification/axi_dram_model.sv
verification/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST) --top-module $(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
